//--- src/fsab_pkg.sv
// FSAB bus package with field widths, request layout, mode codes and credit limits
package fsab_pkg;

	typedef logic [63:0] fsab_data_t;        // One bus beat
	typedef logic [7:0]  fsab_mask_t;        // Byte enables, 1 writes the byte
	typedef logic [30:0] fsab_addr_t;        // Byte address
	typedef logic [3:0]  fsab_len_t;         // Burst length in beats
	typedef logic [3:0]  fsab_did_t;         // Device and subdevice id
	typedef logic        fsab_mode_t;

	localparam fsab_mode_t FSAB_READ  = 1'b0;
	localparam fsab_mode_t FSAB_WRITE = 1'b1;

	// Header fields as they travel through the request and response queues
	typedef struct packed {
		fsab_mode_t mode;
		fsab_did_t  did;
		fsab_did_t  subdid;
		fsab_addr_t addr;
		fsab_len_t  len;
	} fsab_req_t;

	localparam int FSAB_INITIAL_CREDITS = 4;  // Requests in flight, also read slots
	localparam int FSAB_LEN_MAX         = 8;  // Longest burst

	// Wide enough to hold the full credit count
	typedef logic [$clog2(FSAB_INITIAL_CREDITS + 1) - 1:0] fsab_credit_t;

endpackage

//--- src/mem_pkg.sv
// Memory-side package with pair widths, command layout, depth and read latency
package mem_pkg;

	typedef logic [127:0] mem_word_t;   // Beat pair, earlier beat in low half
	typedef logic [15:0]  mem_mask_t;   // Byte enables for a pair
	typedef logic [7:0]   mem_addr_t;   // Pair index, byte address bits 11:4

	typedef struct packed {
		mem_word_t data;
		mem_mask_t mask;
	} mem_wbeat_t;

	typedef struct packed {
		logic      write;
		mem_addr_t addr;
	} mem_cmd_t;

	localparam int MEM_DEPTH        = 256;
	localparam int MEM_READ_LATENCY = 3;  // Command to rd_valid

endpackage

//--- src/sync_fifo.sv
// Show-ahead synchronous FIFO built on a circular buffer
`timescale 1ns/100ps
module sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk0_tb,
	input  logic             rst0_tb,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata,
	output logic             empty,
	output logic             full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] buf_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk0_tb) begin
		if (push)
			buf_q[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign rdata = buf_q[rd_ptr];  // Head is visible without a pop
	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	// Upstream credit schemes must keep every queue within its depth
	assert property (@(posedge clk0_tb) disable iff (rst0_tb) push |-> !full)
		else $error("sync_fifo overflow");
	assert property (@(posedge clk0_tb) disable iff (rst0_tb) pop |-> !empty)
		else $error("sync_fifo underflow");

endmodule

//--- src/fsab_ingress.sv
// FSAB request capture, write-beat pairing and header/data queueing
`timescale 1ns/100ps
module fsab_ingress (
	input  logic                 clk0_tb,
	input  logic                 rst0_tb,
	input  logic                 fsabo_valid,
	input  fsab_pkg::fsab_req_t  fsabo_req,
	input  fsab_pkg::fsab_data_t fsabo_data,
	input  fsab_pkg::fsab_mask_t fsabo_mask,
	input  logic                 req_pop,
	input  logic                 wbeat_pop,
	output fsab_pkg::fsab_req_t  req_head,
	output logic                 req_avail,
	output mem_pkg::mem_wbeat_t  wbeat_head
);
	import fsab_pkg::*;
	import mem_pkg::*;

	fsab_len_t  beats_left;   // Write beats still owed by the host
	fsab_req_t  held_req;     // Write header parked until its last beat
	logic       half_valid;   // Even beat waiting for its odd partner
	fsab_data_t half_data;
	fsab_mask_t half_mask;
	logic       burst_open;
	logic       new_req;
	logic       new_write;
	logic       wr_beat;
	logic       last_beat;
	logic       hdr_push;
	fsab_req_t  hdr_wdata;
	logic       pair_push;
	mem_wbeat_t pair_wdata;
	logic       hdr_empty;

	assign burst_open = (beats_left != '0);
	assign new_req    = fsabo_valid && !burst_open;
	assign new_write  = new_req && (fsabo_req.mode == FSAB_WRITE);
	assign wr_beat    = (fsabo_valid && burst_open) || new_write;
	assign last_beat  = burst_open ? (beats_left == fsab_len_t'(1))
	                               : (fsabo_req.len == fsab_len_t'(1));

	// Reads queue at once, writes once their data is complete
	assign hdr_push  = (new_req && fsabo_req.mode == FSAB_READ) || (wr_beat && last_beat);
	assign hdr_wdata = burst_open ? held_req : fsabo_req;
	assign pair_push = wr_beat && (half_valid || last_beat);

	always_comb begin
		if (half_valid) begin
			pair_wdata.data = {fsabo_data, half_data};
			pair_wdata.mask = {fsabo_mask, half_mask};
		end else begin
			pair_wdata.data = {fsab_data_t'(0), fsabo_data};  // Odd tail beat
			pair_wdata.mask = {fsab_mask_t'(0), fsabo_mask};  // Upper half masked off
		end
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left <= '0;
			half_valid <= 1'b0;
		end else begin
			if (new_write)
				beats_left <= fsabo_req.len - 1'b1;
			else if (fsabo_valid && burst_open)
				beats_left <= beats_left - 1'b1;
			if (wr_beat)
				half_valid <= !half_valid && !last_beat;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (new_write)
			held_req <= fsabo_req;
		if (wr_beat) begin
			half_data <= fsabo_data;
			half_mask <= fsabo_mask;
		end
	end

	sync_fifo #(
		.DEPTH (FSAB_INITIAL_CREDITS),
		.WIDTH ($bits(fsab_req_t))
	) hdr_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (hdr_push),
		.pop     (req_pop),
		.wdata   (hdr_wdata),
		.rdata   (req_head),
		.empty   (hdr_empty),
		.full    ()
	);

	sync_fifo #(
		.DEPTH (FSAB_INITIAL_CREDITS * FSAB_LEN_MAX / 2),  // Pairs, so half the beats
		.WIDTH ($bits(mem_wbeat_t))
	) data_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (pair_push),
		.pop     (wbeat_pop),
		.wdata   (pair_wdata),
		.rdata   (wbeat_head),
		.empty   (),
		.full    ()
	);

	assign req_avail = !hdr_empty;

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		new_write |-> (fsabo_req.len >= 1 && fsabo_req.len <= FSAB_LEN_MAX))
		else $error("FSAB write length out of range");

endmodule

//--- src/mem_sequencer.sv
// Memory command sequencer, one command per pair, with read-credit gating
`timescale 1ns/100ps
module mem_sequencer (
	input  logic                clk0_tb,
	input  logic                rst0_tb,
	input  fsab_pkg::fsab_req_t req_head,
	input  logic                req_avail,
	input  mem_pkg::mem_wbeat_t wbeat_head,
	input  logic                resp_done,
	output logic                req_pop,
	output logic                wbeat_pop,
	output logic                cmd_valid,
	output mem_pkg::mem_cmd_t   cmd,
	output mem_pkg::mem_wbeat_t wdata,
	output logic                hdr_push,
	output fsab_pkg::fsab_req_t hdr_req,
	output logic                fsabo_credit
);
	import fsab_pkg::*;
	import mem_pkg::*;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_WRITE, SEQ_READ} seq_state_e;

	seq_state_e   state;
	fsab_credit_t rd_credits;   // Free response slots in egress
	fsab_len_t    pairs_left;
	mem_addr_t    pair_addr;
	fsab_len_t    pairs_total;
	mem_addr_t    head_addr;
	logic         is_write;
	logic         start;
	logic         last_cmd;

	assign is_write    = (req_head.mode == FSAB_WRITE);
	assign pairs_total = (req_head.len + 1'b1) >> 1;  // ceil(len/2)
	assign head_addr   = req_head.addr[11:4];

	// First command goes out in the cycle the request is taken
	assign start     = (state == SEQ_IDLE) && req_avail && (is_write || rd_credits != '0);
	assign cmd_valid = start || (state != SEQ_IDLE);
	assign last_cmd  = (state == SEQ_IDLE) ? (pairs_total == fsab_len_t'(1))
	                                       : (pairs_left == fsab_len_t'(1));

	assign cmd.write = (state == SEQ_WRITE) || (state == SEQ_IDLE && is_write);
	assign cmd.addr  = (state == SEQ_IDLE) ? head_addr : pair_addr;
	assign wdata     = wbeat_head;

	assign wbeat_pop    = cmd_valid && cmd.write;
	assign req_pop      = cmd_valid && last_cmd;
	assign fsabo_credit = req_pop;                 // Request fully consumed
	assign hdr_push     = start && !is_write;
	assign hdr_req      = req_head;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state      <= SEQ_IDLE;
			pairs_left <= '0;
			pair_addr  <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (start && !last_cmd) begin
						state      <= is_write ? SEQ_WRITE : SEQ_READ;
						pairs_left <= pairs_total - 1'b1;
						pair_addr  <= head_addr + 1'b1;
					end
				end
				default: begin
					pairs_left <= pairs_left - 1'b1;
					pair_addr  <= pair_addr + 1'b1;
					if (last_cmd)
						state <= SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			rd_credits <= fsab_credit_t'(FSAB_INITIAL_CREDITS);
		end else begin
			case ({hdr_push, resp_done})
				2'b10:   rd_credits <= rd_credits - 1'b1;  // Read start
				2'b01:   rd_credits <= rd_credits + 1'b1;  // Response drained
				default: rd_credits <= rd_credits;
			endcase
		end
	end

	// Egress must never return more slots than were handed out
	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		rd_credits <= FSAB_INITIAL_CREDITS)
		else $error("Read credit count above initial value");

endmodule

//--- src/mem_backend.sv
// Pair-wide memory with byte-masked writes and fixed-latency read pipeline
`timescale 1ns/100ps
module mem_backend (
	input  logic                clk0_tb,
	input  logic                rst0_tb,
	input  logic                cmd_valid,
	input  mem_pkg::mem_cmd_t   cmd,
	input  mem_pkg::mem_wbeat_t wdata,
	output logic                rd_valid,
	output mem_pkg::mem_word_t  rd_data
);
	import mem_pkg::*;

	mem_word_t                   mem_q [MEM_DEPTH];
	logic [MEM_READ_LATENCY-1:0] pipe_valid;
	mem_word_t                   pipe_data [MEM_READ_LATENCY];
	logic                        rd_cmd;

	assign rd_cmd = cmd_valid && !cmd.write;

	always_ff @(posedge clk0_tb) begin
		if (cmd_valid && cmd.write) begin
			for (int i = 0; i < $bits(mem_mask_t); i++) begin
				if (wdata.mask[i])
					mem_q[cmd.addr][8*i +: 8] <= wdata.data[8*i +: 8];  // Masked byte lane
			end
		end
	end

	// Valid tags shift with the data so reads overlap
	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[MEM_READ_LATENCY-2:0], rd_cmd};
	end

	always_ff @(posedge clk0_tb) begin
		pipe_data[0] <= mem_q[cmd.addr];
		for (int s = 1; s < MEM_READ_LATENCY; s++)
			pipe_data[s] <= pipe_data[s-1];
	end

	assign rd_valid = pipe_valid[MEM_READ_LATENCY-1];
	assign rd_data  = pipe_data[MEM_READ_LATENCY-1];

endmodule

//--- src/fsab_egress.sv
// Read response queues and pair-to-beat unpacking onto fsabi
`timescale 1ns/100ps
module fsab_egress (
	input  logic                 clk0_tb,
	input  logic                 rst0_tb,
	input  logic                 hdr_push,
	input  fsab_pkg::fsab_req_t  hdr_req,
	input  logic                 rd_valid,
	input  mem_pkg::mem_word_t   rd_data,
	output logic                 fsabi_valid,
	output fsab_pkg::fsab_did_t  fsabi_did,
	output fsab_pkg::fsab_did_t  fsabi_subdid,
	output fsab_pkg::fsab_data_t fsabi_data,
	output logic                 resp_done
);
	import fsab_pkg::*;
	import mem_pkg::*;

	fsab_req_t  hdr_head;
	mem_word_t  pair_head;
	fsab_data_t pair_hi;
	fsab_data_t pair_lo;
	logic       hdr_empty;
	logic       pair_empty;
	logic       active;      // Response in progress
	fsab_len_t  beat;        // Beat index within the response
	logic       last_beat;
	logic       hdr_pop;
	logic       pair_pop;

	assign {pair_hi, pair_lo} = pair_head;
	assign last_beat = (beat == hdr_head.len - 1'b1);
	assign hdr_pop   = active && last_beat;
	assign pair_pop  = active && (beat[0] || last_beat);  // High half or odd tail

	assign fsabi_valid  = active;
	assign fsabi_did    = hdr_head.did;
	assign fsabi_subdid = hdr_head.subdid;
	assign fsabi_data   = beat[0] ? pair_hi : pair_lo;
	assign resp_done    = hdr_pop;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			active <= 1'b0;
			beat   <= '0;
		end else if (!active) begin
			if (!hdr_empty && !pair_empty) begin
				active <= 1'b1;
				beat   <= '0;
			end
		end else if (last_beat) begin
			active <= 1'b0;
		end else begin
			beat <= beat + 1'b1;
		end
	end

	sync_fifo #(
		.DEPTH (FSAB_INITIAL_CREDITS),
		.WIDTH ($bits(fsab_req_t))
	) hdr_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (hdr_push),
		.pop     (hdr_pop),
		.wdata   (hdr_req),
		.rdata   (hdr_head),
		.empty   (hdr_empty),
		.full    ()
	);

	sync_fifo #(
		.DEPTH (FSAB_INITIAL_CREDITS * FSAB_LEN_MAX / 2),
		.WIDTH ($bits(mem_word_t))
	) pair_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (rd_valid),
		.pop     (pair_pop),
		.wdata   (rd_data),
		.rdata   (pair_head),
		.empty   (pair_empty),
		.full    ()
	);

endmodule

//--- src/fsab_bridge.sv
// FSAB to in-fabric memory bridge top level
`timescale 1ns/100ps
module fsab_bridge (
	input  logic                 clk0_tb,
	input  logic                 rst0_tb,
	input  logic                 fsabo_valid,
	input  fsab_pkg::fsab_req_t  fsabo_req,
	input  fsab_pkg::fsab_data_t fsabo_data,
	input  fsab_pkg::fsab_mask_t fsabo_mask,
	output logic                 fsabo_credit,
	output logic                 fsabi_valid,
	output fsab_pkg::fsab_did_t  fsabi_did,
	output fsab_pkg::fsab_did_t  fsabi_subdid,
	output fsab_pkg::fsab_data_t fsabi_data
);
	import fsab_pkg::*;
	import mem_pkg::*;

	fsab_req_t  req_head;
	logic       req_avail;
	mem_wbeat_t wbeat_head;
	logic       req_pop;
	logic       wbeat_pop;
	logic       cmd_valid;
	mem_cmd_t   cmd;
	mem_wbeat_t wdata;
	logic       hdr_push;
	fsab_req_t  hdr_req;
	logic       rd_valid;
	mem_word_t  rd_data;
	logic       resp_done;   // Returns a read slot

	fsab_ingress fsab_ingress_inst (
		.clk0_tb, .rst0_tb, .fsabo_valid, .fsabo_req, .fsabo_data, .fsabo_mask,
		.req_pop, .wbeat_pop, .req_head, .req_avail, .wbeat_head
	);

	mem_sequencer mem_sequencer_inst (
		.clk0_tb, .rst0_tb, .req_head, .req_avail, .wbeat_head, .resp_done,
		.req_pop, .wbeat_pop, .cmd_valid, .cmd, .wdata, .hdr_push, .hdr_req, .fsabo_credit
	);

	mem_backend mem_backend_inst (
		.clk0_tb, .rst0_tb, .cmd_valid, .cmd, .wdata, .rd_valid, .rd_data
	);

	fsab_egress fsab_egress_inst (
		.clk0_tb, .rst0_tb, .hdr_push, .hdr_req, .rd_valid, .rd_data,
		.fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data, .resp_done
	);

endmodule

//--- dv/fsab_bridge_tb.sv
// Testbench for the FSAB memory bridge with host model, reference memory and response checks
`timescale 1ns/100ps
module fsab_bridge_tb;
	import fsab_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int NUM_REQS    = 29;   // 16 + 3 + 4 + 6
	localparam int WATCHDOG_NS = NUM_REQS * (FSAB_LEN_MAX + 40) * CLK_PERIOD;

	logic       clk0_tb;
	logic       rst0_tb;
	logic       fsabo_valid;
	fsab_req_t  fsabo_req;
	fsab_data_t fsabo_data;
	fsab_mask_t fsabo_mask;
	logic       fsabo_credit;
	logic       fsabi_valid;
	fsab_did_t  fsabi_did;
	fsab_did_t  fsabi_subdid;
	fsab_data_t fsabi_data;

	logic [7:0] ref_mem [4096];      // Byte-wise model of the memory
	fsab_data_t exp_data [256];      // Expected beats in read order
	fsab_did_t  exp_did [256];
	fsab_did_t  exp_subdid [256];
	logic       exp_last [256];
	int         wr_idx = 0;
	int         rd_idx;              // Beats received
	int         req_sent = 0;
	int         credits_back;
	int         error_count = 0;
	int         seed = 57017;

	fsab_bridge fsab_bridge_inst (
		.clk0_tb, .rst0_tb, .fsabo_valid, .fsabo_req, .fsabo_data, .fsabo_mask,
		.fsabo_credit, .fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data
	);

	initial begin
		clk0_tb = 1'b0;
		forever #(CLK_PERIOD / 2) clk0_tb = ~clk0_tb;
	end

	always @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			rd_idx       <= 0;
			credits_back <= 0;
		end else begin
			if (fsabi_valid)
				rd_idx <= rd_idx + 1;
			if (fsabo_credit)
				credits_back <= credits_back + 1;
		end
	end

	task automatic log_error(input string msg);
		error_count++;
		$display("** Error @ %0d ns: %s", $time, msg);
	endtask

	task automatic next_cycle();
		@(posedge clk0_tb);
		#DRIVE_DELAY;
	endtask

	task automatic wait_for_credit();
		while (req_sent - credits_back >= FSAB_INITIAL_CREDITS)
			next_cycle();
	endtask

	task automatic send_write(input fsab_addr_t addr, input int len, input logic full_mask);
		fsab_req_t req;
		int        gap;
		wait_for_credit();
		req = '{mode: FSAB_WRITE, did: fsab_did_t'($random(seed)),
		        subdid: fsab_did_t'($random(seed)), addr: addr, len: fsab_len_t'(len)};
		for (int b = 0; b < len; b++) begin
			fsabo_valid = 1'b1;
			if (b == 0)
				fsabo_req = req;
			else
				fsabo_req = ~req;   // Only the first beat carries the header
			fsabo_data  = {$random(seed), $random(seed)};
			fsabo_mask  = full_mask ? 8'hff : fsab_mask_t'($random(seed));
			for (int i = 0; i < 8; i++) begin
				if (fsabo_mask[i])
					ref_mem[addr + 8 * b + i] = fsabo_data[8*i +: 8];
			end
			if (b == 0)
				req_sent++;
			next_cycle();
			fsabo_valid = 1'b0;
			gap = $unsigned($random(seed)) % 3;   // Idle cycles between beats
			repeat (gap) next_cycle();
		end
	endtask

	task automatic send_read(input fsab_addr_t addr, input int len);
		fsab_req_t req;
		wait_for_credit();
		req = '{mode: FSAB_READ, did: fsab_did_t'($random(seed)),
		        subdid: fsab_did_t'($random(seed)), addr: addr, len: fsab_len_t'(len)};
		for (int b = 0; b < len; b++) begin
			for (int i = 0; i < 8; i++)
				exp_data[wr_idx][8*i +: 8] = ref_mem[addr + 8 * b + i];
			exp_did[wr_idx]    = req.did;
			exp_subdid[wr_idx] = req.subdid;
			exp_last[wr_idx]   = (b == len - 1);
			wr_idx++;
		end
		fsabo_valid = 1'b1;
		fsabo_req   = req;
		req_sent++;
		next_cycle();
		fsabo_valid = 1'b0;
	endtask

	// Nothing leaves the bridge before the host has asked for something
	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		(req_sent == 0) |-> (!fsabo_credit && !fsabi_valid))
		else log_error("output activity before the first request");

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		fsabi_valid |-> (rd_idx != wr_idx))
		else log_error("fsabi beat with no read outstanding");

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		fsabi_valid |-> (fsabi_data == exp_data[rd_idx]))
		else log_error($sformatf("fsabi_data %h, expected %h",
			$sampled(fsabi_data), exp_data[$sampled(rd_idx)]));

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		fsabi_valid |-> (fsabi_did == exp_did[rd_idx] && fsabi_subdid == exp_subdid[rd_idx]))
		else log_error("fsabi_did or fsabi_subdid differs from the read request");

	// Burst stays contiguous, then drops right after its last beat
	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		(fsabi_valid && !exp_last[rd_idx]) |=> fsabi_valid)
		else log_error("fsabi_valid dropped inside a response");

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		(fsabi_valid && exp_last[rd_idx]) |=> !fsabi_valid)
		else log_error("fsabi_valid held past the response length");

	assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		fsabo_credit |-> (credits_back < req_sent))
		else log_error("more credits returned than requests sent");

	initial begin
		fsabo_valid = 1'b0;
		fsabo_req   = '0;
		fsabo_data  = '0;
		fsabo_mask  = '0;
		rst0_tb     = 1'b1;
		repeat (4) @(posedge clk0_tb);
		#DRIVE_DELAY rst0_tb = 1'b0;
		repeat (5) next_cycle();   // Quiet period after reset
		for (int len = 1; len <= FSAB_LEN_MAX; len++) begin
			send_write(fsab_addr_t'(64 * len), len, 1'b1);
			send_read(fsab_addr_t'(64 * len), len);
		end
		send_write(31'h800, 6, 1'b1);
		send_write(31'h800, 5, 1'b0);   // Partial overwrite
		send_read(31'h800, 6);          // Beat 5 keeps the old data
		for (int k = 0; k < 4; k++)
			send_write(fsab_addr_t'(32'hC00 + 64 * k), FSAB_LEN_MAX, 1'b1);
		for (int k = 0; k < 6; k++)
			send_read(fsab_addr_t'(32'hC00 + 64 * (k % 4)), FSAB_LEN_MAX);  // Drains read credits
		while (credits_back != req_sent || rd_idx != wr_idx)
			next_cycle();
		repeat (4) next_cycle();
		assert (credits_back == req_sent)
			else log_error("credit count differs from request count");
		assert (rd_idx == wr_idx)
			else log_error("received beat count differs from expected");
		$display("Errors: %0d, beats: %0d of %0d, credits: %0d of %0d requests",
			error_count, rd_idx, wr_idx, credits_back, req_sent);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all requests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- fsab_bridge.f
src/fsab_pkg.sv
src/mem_pkg.sv
src/sync_fifo.sv
src/fsab_ingress.sv
src/mem_sequencer.sv
src/mem_backend.sv
src/fsab_egress.sv
src/fsab_bridge.sv
dv/fsab_bridge_tb.sv

//--- Bender.yml
package:
  name: fsab_bridge

sources:
  - src/fsab_pkg.sv
  - src/mem_pkg.sv
  - src/sync_fifo.sv
  - src/fsab_ingress.sv
  - src/mem_sequencer.sv
  - src/mem_backend.sv
  - src/fsab_egress.sv
  - src/fsab_bridge.sv
  - target: simulation
    files:
      - dv/fsab_bridge_tb.sv
